//--- source/rvv_lite_pkg.sv
package rvv_lite_pkg;

    // Vector geometry for SEW 8 and LMUL 1 only
    localparam int VLEN       = 64;
    localparam int SEW        = 8;
    localparam int NUM_ELEM   = VLEN / SEW;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;

    // Queue depth doubles as the issuer's starting credit count
    localparam int CQ_DEPTH = 4;
    localparam int TAG_W    = 8;
    localparam int CNT_W    = 16;

    // OP-V encoding fields
    localparam logic [6:0] OPCODE_OPV   = 7'b1010111;
    localparam logic [2:0] FUNCT3_OPIVV = 3'b000;
    localparam logic [2:0] FUNCT3_OPIVI = 3'b011;
    localparam logic [5:0] FUNCT6_VADD  = 6'b000000;
    localparam logic [5:0] FUNCT6_VSUB  = 6'b000010;
    localparam logic [5:0] FUNCT6_VSADD = 6'b100001;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_SADD
    } valu_op_e;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opivv_t;

    // Same layout with the immediate as middle field
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] simm5;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opivi_t;

    typedef union packed {
        opivv_t vv;
        opivi_t vi;
    } inst_word_u;

    typedef logic [VLEN-1:0] vreg_t;

endpackage

//--- source/rvv_lite_if.sv
`timescale 1ns/1ps

// Issue stage to ALU
interface exec_if;
    logic                                  valid;
    rvv_lite_pkg::valu_op_e                op;
    logic [rvv_lite_pkg::VREG_IDX_W-1:0]   vd;
    rvv_lite_pkg::vreg_t                   src_a;
    rvv_lite_pkg::vreg_t                   src_b;
    logic [rvv_lite_pkg::TAG_W-1:0]        tag;

    modport issue (output valid, op, vd, src_a, src_b, tag);
    modport alu   (input  valid, op, vd, src_a, src_b, tag);
endinterface

// ALU result to VRF, tag counter and retire port
interface wb_if;
    logic                                  valid;
    logic [rvv_lite_pkg::VREG_IDX_W-1:0]   vd;
    rvv_lite_pkg::vreg_t                   data;
    logic                                  vxsat;
    logic [rvv_lite_pkg::TAG_W-1:0]        tag;

    modport alu  (output valid, vd, data, vxsat, tag);
    modport sink (input  valid, vd, data, vxsat, tag);
endinterface

//--- source/rvv_cmd_queue.sv
`timescale 1ns/1ps

module rvv_cmd_queue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  rvv_lite_pkg::inst_word_u push_inst,
    input  logic                     pop,
    output logic                     head_valid,
    output rvv_lite_pkg::inst_word_u head_inst,
    output logic                     credit_return
);

    rvv_lite_pkg::inst_word_u mem [rvv_lite_pkg::CQ_DEPTH];

    logic [$clog2(rvv_lite_pkg::CQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(rvv_lite_pkg::CQ_DEPTH)-1:0] rd_ptr;
    logic [$clog2(rvv_lite_pkg::CQ_DEPTH):0]   count;
    logic                                      do_pop;

    assign head_valid    = (count != '0);
    assign head_inst     = mem[rd_ptr];
    assign do_pop        = pop && head_valid;
    // One credit back per entry freed
    assign credit_return = do_pop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - do_pop;
        end
    end

    // Issuer credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_inst;
        end
    end

endmodule

//--- source/rvv_issue_fsm.sv
`timescale 1ns/1ps

module rvv_issue_fsm (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                head_valid,
    input  rvv_lite_pkg::inst_word_u            head_inst,
    output logic                                pop,
    output logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_a,
    output logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_b,
    input  rvv_lite_pkg::vreg_t                 rd_data_a,
    input  rvv_lite_pkg::vreg_t                 rd_data_b,
    input  logic [rvv_lite_pkg::TAG_W-1:0]      next_tag,
    output logic                                tag_take,
    output logic                                trap_valid,
    output logic [rvv_lite_pkg::TAG_W-1:0]      trap_tag,
    input  logic                                trap_ready,
    exec_if.issue                               exec
);

    typedef enum logic [1:0] {
        RUN,
        STALL,
        TRAP
    } state_e;

    state_e                  state;
    logic                    is_vv;
    logic                    is_vi;
    logic                    legal;
    logic                    hazard;
    rvv_lite_pkg::valu_op_e  dec_op;
    logic [rvv_lite_pkg::SEW-1:0] imm_elem;

    // Same word seen as OPIVV and as OPIVI
    always_comb begin
        is_vv = (head_inst.vv.opcode == rvv_lite_pkg::OPCODE_OPV) &&
                (head_inst.vv.funct3 == rvv_lite_pkg::FUNCT3_OPIVV) && head_inst.vv.vm;
        is_vi = (head_inst.vi.opcode == rvv_lite_pkg::OPCODE_OPV) &&
                (head_inst.vi.funct3 == rvv_lite_pkg::FUNCT3_OPIVI) && head_inst.vi.vm;
        dec_op = rvv_lite_pkg::OP_ADD;
        legal  = 1'b0;
        case (head_inst.vv.funct6)
            rvv_lite_pkg::FUNCT6_VADD: begin
                legal = is_vv || is_vi;
            end
            rvv_lite_pkg::FUNCT6_VSUB: begin
                dec_op = rvv_lite_pkg::OP_SUB;
                legal  = is_vv;
            end
            rvv_lite_pkg::FUNCT6_VSADD: begin
                dec_op = rvv_lite_pkg::OP_SADD;
                legal  = is_vv;
            end
            default: legal = 1'b0;
        endcase
    end

    // vs1 only counts as a source for the vector-vector form
    assign hazard = exec.valid && ((head_inst.vv.vs2 == exec.vd) ||
                                   (is_vv && head_inst.vv.vs1 == exec.vd));

    assign rd_idx_a   = head_inst.vv.vs2;
    assign rd_idx_b   = head_inst.vv.vs1;
    assign imm_elem   = {{(rvv_lite_pkg::SEW-5){head_inst.vi.simm5[4]}}, head_inst.vi.simm5};
    assign pop        = (state == RUN) && head_valid && !hazard;
    assign tag_take   = pop;
    assign trap_valid = (state == TRAP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RUN;
            trap_tag <= '0;
        end else begin
            case (state)
                RUN: begin
                    if (head_valid && hazard) begin
                        state <= STALL;
                    end else if (pop && !legal) begin
                        state    <= TRAP;
                        trap_tag <= next_tag;
                    end
                end
                STALL: state <= RUN;
                TRAP: begin
                    if (trap_ready) begin
                        state <= RUN;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= pop && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && legal) begin
            exec.op    <= dec_op;
            exec.vd    <= head_inst.vv.vd;
            exec.src_a <= rd_data_a;
            exec.src_b <= is_vi ? {rvv_lite_pkg::NUM_ELEM{imm_elem}} : rd_data_b;
            exec.tag   <= next_tag;
        end
    end

endmodule

//--- source/rvv_tag_counter.sv
`timescale 1ns/1ps

module rvv_tag_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tag_take,
    output logic [rvv_lite_pkg::TAG_W-1:0] next_tag,
    wb_if.sink                             wb,
    output logic [rvv_lite_pkg::CNT_W-1:0] retired_count
);

    // Tags wrap and traps consume one too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_tag <= '0;
        end else if (tag_take) begin
            next_tag <= next_tag + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_count <= '0;
        end else if (wb.valid) begin
            retired_count <= retired_count + 1'b1;
        end
    end

endmodule

//--- source/rvv_vrf.sv
`timescale 1ns/1ps

module rvv_vrf (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_a,
    input  logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_b,
    output rvv_lite_pkg::vreg_t                 rd_data_a,
    output rvv_lite_pkg::vreg_t                 rd_data_b,
    wb_if.sink                                  wb
);

    rvv_lite_pkg::vreg_t regs [rvv_lite_pkg::NUM_VREG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rvv_lite_pkg::NUM_VREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.vd] <= wb.data;
        end
    end

    // Write-through so a same-cycle reader sees the new value
    assign rd_data_a = (wb.valid && wb.vd == rd_idx_a) ? wb.data : regs[rd_idx_a];
    assign rd_data_b = (wb.valid && wb.vd == rd_idx_b) ? wb.data : regs[rd_idx_b];

endmodule

//--- source/rvv_valu.sv
`timescale 1ns/1ps

module rvv_valu (
    input  logic  clk,
    input  logic  rst_n,
    exec_if.alu   exec,
    wb_if.alu     wb
);

    rvv_lite_pkg::vreg_t               result;
    logic [rvv_lite_pkg::NUM_ELEM-1:0] elem_sat;
    logic                              vxsat;

    for (genvar i = 0; i < rvv_lite_pkg::NUM_ELEM; i++) begin : g_elem
        logic [rvv_lite_pkg::SEW-1:0] a;
        logic [rvv_lite_pkg::SEW-1:0] b;
        logic [rvv_lite_pkg::SEW:0]   sum_ext;
        logic [rvv_lite_pkg::SEW-1:0] sat_val;
        logic                         ovf;

        assign a       = exec.src_a[i*rvv_lite_pkg::SEW +: rvv_lite_pkg::SEW];
        assign b       = exec.src_b[i*rvv_lite_pkg::SEW +: rvv_lite_pkg::SEW];
        // One extra sign bit exposes signed overflow
        assign sum_ext = {a[rvv_lite_pkg::SEW-1], a} + {b[rvv_lite_pkg::SEW-1], b};
        assign ovf     = sum_ext[rvv_lite_pkg::SEW] ^ sum_ext[rvv_lite_pkg::SEW-1];
        // Clamp to 127 or -128 by the sign of the true sum
        assign sat_val = sum_ext[rvv_lite_pkg::SEW] ? {1'b1, {(rvv_lite_pkg::SEW-1){1'b0}}}
                                                    : {1'b0, {(rvv_lite_pkg::SEW-1){1'b1}}};

        assign elem_sat[i] = (exec.op == rvv_lite_pkg::OP_SADD) && ovf;
        assign result[i*rvv_lite_pkg::SEW +: rvv_lite_pkg::SEW] =
            (exec.op == rvv_lite_pkg::OP_SUB) ? a - b :
            elem_sat[i]                       ? sat_val :
                                                sum_ext[rvv_lite_pkg::SEW-1:0];
    end

    assign vxsat = |elem_sat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            wb.vd    <= exec.vd;
            wb.data  <= result;
            wb.vxsat <= vxsat;
            wb.tag   <= exec.tag;
        end
    end

endmodule

//--- source/rvv_lite_backend.sv
`timescale 1ns/1ps

module rvv_lite_backend (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                inst_valid,
    input  logic [31:0]                         inst,
    output logic                                credit_return,
    output logic                                retire_valid,
    output logic [rvv_lite_pkg::VREG_IDX_W-1:0] retire_vd,
    output rvv_lite_pkg::vreg_t                 retire_data,
    output logic                                retire_vxsat,
    output logic [rvv_lite_pkg::TAG_W-1:0]      retire_tag,
    output logic                                trap_valid,
    output logic [rvv_lite_pkg::TAG_W-1:0]      trap_tag,
    input  logic                                trap_ready,
    output logic [rvv_lite_pkg::CNT_W-1:0]      retired_count
);

    logic                                head_valid;
    rvv_lite_pkg::inst_word_u            head_inst;
    logic                                pop;
    logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_a;
    logic [rvv_lite_pkg::VREG_IDX_W-1:0] rd_idx_b;
    rvv_lite_pkg::vreg_t                 rd_data_a;
    rvv_lite_pkg::vreg_t                 rd_data_b;
    logic [rvv_lite_pkg::TAG_W-1:0]      next_tag;
    logic                                tag_take;

    exec_if exec_bus ();
    wb_if   wb_bus ();

    rvv_cmd_queue u_cmd_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (inst_valid),
        .push_inst     (inst),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_inst     (head_inst),
        .credit_return (credit_return)
    );

    rvv_issue_fsm u_issue_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .pop        (pop),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .next_tag   (next_tag),
        .tag_take   (tag_take),
        .trap_valid (trap_valid),
        .trap_tag   (trap_tag),
        .trap_ready (trap_ready),
        .exec       (exec_bus)
    );

    rvv_tag_counter u_tag_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .tag_take      (tag_take),
        .next_tag      (next_tag),
        .wb            (wb_bus),
        .retired_count (retired_count)
    );

    rvv_vrf u_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb        (wb_bus)
    );

    rvv_valu u_valu (
        .clk   (clk),
        .rst_n (rst_n),
        .exec  (exec_bus),
        .wb    (wb_bus)
    );

    // Retire port is the write-back bus itself
    assign retire_valid = wb_bus.valid;
    assign retire_vd    = wb_bus.vd;
    assign retire_data  = wb_bus.data;
    assign retire_vxsat = wb_bus.vxsat;
    assign retire_tag   = wb_bus.tag;

endmodule

//--- include/rvv_lite_ref.svh
`ifndef RVV_LITE_REF_SVH
`define RVV_LITE_REF_SVH

// Unmasked OPIVV word for vd = vs2 op vs1
function automatic logic [31:0] encode_vv(input logic [5:0] funct6, input logic [4:0] vd,
                                          input logic [4:0] vs2, input logic [4:0] vs1);
    return {funct6, 1'b1, vs2, vs1, rvv_lite_pkg::FUNCT3_OPIVV, vd, rvv_lite_pkg::OPCODE_OPV};
endfunction

function automatic logic [31:0] encode_vi(input logic [5:0] funct6, input logic [4:0] vd,
                                          input logic [4:0] vs2, input logic [4:0] simm5);
    return {funct6, 1'b1, vs2, simm5, rvv_lite_pkg::FUNCT3_OPIVI, vd, rvv_lite_pkg::OPCODE_OPV};
endfunction

// simm5 sign-extended into every element
function automatic logic [63:0] splat_imm(input logic [4:0] simm5);
    return {rvv_lite_pkg::NUM_ELEM{{{3{simm5[4]}}, simm5}}};
endfunction

// Elementwise result for a legal funct6 with vxsat set on any clamp
function automatic logic [63:0] expected_result(input logic [5:0] funct6, input logic [63:0] a,
                                                input logic [63:0] b, output logic vxsat);
    logic [63:0]   res;
    int            sum;
    logic [7:0]    ea;
    logic [7:0]    eb;
    res   = '0;
    vxsat = 1'b0;
    for (int i = 0; i < rvv_lite_pkg::NUM_ELEM; i++) begin
        ea = a[i*8 +: 8];
        eb = b[i*8 +: 8];
        if (funct6 == rvv_lite_pkg::FUNCT6_VSUB) begin
            res[i*8 +: 8] = ea - eb;
        end else if (funct6 == rvv_lite_pkg::FUNCT6_VSADD) begin
            sum = $signed(ea) + $signed(eb);
            if (sum > 127) begin
                sum   = 127;
                vxsat = 1'b1;
            end else if (sum < -128) begin
                sum   = -128;
                vxsat = 1'b1;
            end
            res[i*8 +: 8] = sum[7:0];
        end else begin
            res[i*8 +: 8] = ea + eb;
        end
    end
    return res;
endfunction

`endif

//--- dv/rvv_lite_tb.sv
`timescale 1ns/1ps

module rvv_lite_tb;

    `include "rvv_lite_ref.svh"

    // Words sent by all tests with bursts counted at their longest
    localparam int N_WORDS        = 6 + 200 + 14 + 4 * 8 + 7;
    localparam int TIMEOUT_CYCLES = 40 * N_WORDS + 200;

    typedef struct packed {
        logic [rvv_lite_pkg::TAG_W-1:0]      tag;
        logic [rvv_lite_pkg::VREG_IDX_W-1:0] vd;
        logic [63:0]                         data;
        logic                                vxsat;
    } ret_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        trap_ready;
    logic        credit_return;
    logic        retire_valid;
    logic [4:0]  retire_vd;
    logic [63:0] retire_data;
    logic        retire_vxsat;
    logic [7:0]  retire_tag;
    logic        trap_valid;
    logic [7:0]  trap_tag;
    logic [15:0] retired_count;

    ret_t        exp_q[$];
    logic [7:0]  trap_q[$];
    logic [63:0] shadow [32];
    logic [7:0]  tag_exp = '0;
    integer      seed = 32'h21e7094f;
    int          sent = 0;
    int          returned = 0;
    int          legal_sent = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          cycles = 0;
    int          prev_vd;
    int          burst_len;

    rvv_lite_backend dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .credit_return (credit_return),
        .retire_valid  (retire_valid),
        .retire_vd     (retire_vd),
        .retire_data   (retire_data),
        .retire_vxsat  (retire_vxsat),
        .retire_tag    (retire_tag),
        .trap_valid    (trap_valid),
        .trap_tag      (trap_tag),
        .trap_ready    (trap_ready),
        .retired_count (retired_count)
    );

    always #10 clk = ~clk;

    function automatic int pick(input int n);
        return {$random(seed)} % n;
    endfunction

    // Waits for a credit, then drives one word for one cycle
    task automatic issue_word(input logic [31:0] w);
        while (sent - returned >= rvv_lite_pkg::CQ_DEPTH) begin
            @(negedge clk);
        end
        inst_valid = 1'b1;
        inst       = w;
        sent++;
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic send_vv(input logic [5:0] f6, input int vd, input int vs2, input int vs1);
        ret_t e;
        logic vx;
        e.data  = expected_result(f6, shadow[vs2], shadow[vs1], vx);
        e.vxsat = vx;
        e.tag   = tag_exp;
        e.vd    = vd[4:0];
        shadow[vd] = e.data;
        exp_q.push_back(e);
        tag_exp++;
        legal_sent++;
        issue_word(encode_vv(f6, vd[4:0], vs2[4:0], vs1[4:0]));
    endtask

    task automatic send_vi(input int vd, input int vs2, input logic [4:0] simm5);
        ret_t e;
        logic vx;
        e.data  = expected_result(rvv_lite_pkg::FUNCT6_VADD, shadow[vs2], splat_imm(simm5), vx);
        e.vxsat = vx;
        e.tag   = tag_exp;
        e.vd    = vd[4:0];
        shadow[vd] = e.data;
        exp_q.push_back(e);
        tag_exp++;
        legal_sent++;
        issue_word(encode_vi(rvv_lite_pkg::FUNCT6_VADD, vd[4:0], vs2[4:0], simm5));
    endtask

    // Illegal word still takes a tag
    task automatic send_illegal(input logic [5:0] f6, input int vd);
        trap_q.push_back(tag_exp);
        tag_exp++;
        issue_word(encode_vv(f6, vd[4:0], 5'd1, 5'd2));
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0 || trap_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        // All words are popped by now and their credits are back
        checks++;
        assert (returned == sent) else begin
            errors++;
            $display("[ERROR] credit_return pulses got %h expected %h", returned, sent);
        end
        $display("Test %-12s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Compares every retirement and trap against the expected queues
    always @(posedge clk) begin
        ret_t e;
        if (rst_n) begin
            if (credit_return) begin
                returned++;
            end
            if (retire_valid && exp_q.size() == 0) begin
                errors++;
                $display("Unexpected retirement with tag %h and no instruction pending", retire_tag);
            end else if (retire_valid) begin
                e = exp_q.pop_front();
                checks++;
                assert (retire_tag == e.tag) else begin
                    errors++;
                    $display("[ERROR] retire_tag got %h expected %h", retire_tag, e.tag);
                end
                assert (retire_vd == e.vd) else begin
                    errors++;
                    $display("[ERROR] retire_vd got %h expected %h", retire_vd, e.vd);
                end
                assert (retire_data == e.data) else begin
                    errors++;
                    $display("[ERROR] retire_data got %h expected %h", retire_data, e.data);
                end
                assert (retire_vxsat == e.vxsat) else begin
                    errors++;
                    $display("[ERROR] retire_vxsat got %h expected %h", retire_vxsat, e.vxsat);
                end
            end
            if (trap_valid && trap_q.size() == 0) begin
                errors++;
                $display("Trap raised with tag %h while no illegal word was sent", trap_tag);
            end else if (trap_valid) begin
                checks++;
                assert (trap_tag == trap_q[0]) else begin
                    errors++;
                    $display("[ERROR] trap_tag got %h expected %h", trap_tag, trap_q[0]);
                end
                if (trap_ready) begin
                    void'(trap_q.pop_front());
                end
            end
        end
    end

    // Acknowledge after a random hold during which the trap stays up
    always begin
        int hold;
        @(negedge clk);
        if (trap_valid && !trap_ready) begin
            hold = pick(6);
            repeat (hold) begin
                @(negedge clk);
                assert (trap_valid) else begin
                    errors++;
                    $display("trap_valid dropped before trap_ready was given");
                end
            end
            trap_ready = 1'b1;
            @(negedge clk);
            trap_ready = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d retirements and %0d traps outstanding",
                     cycles, exp_q.size(), trap_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        trap_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int r = 1; r <= 6; r++) begin
            send_vi(r, 0, 5'(r * 5 - 14));
        end
        end_test("fill");

        prev_vd = 1;
        for (int n = 0; n < 200; n++) begin
            send_vv(pick(2) ? rvv_lite_pkg::FUNCT6_VADD : rvv_lite_pkg::FUNCT6_VSUB,
                    1 + pick(6), pick(2) ? prev_vd : 1 + pick(6), 1 + pick(6));
            prev_vd = exp_q.size() != 0 ? int'(exp_q[$].vd) : prev_vd;
        end
        end_test("chains");

        // v7 builds up to 120 and v8 down to -128
        send_vi(7, 0, 5'd15);
        send_vi(8, 0, 5'h10);
        for (int n = 0; n < 3; n++) begin
            send_vv(rvv_lite_pkg::FUNCT6_VADD, 7, 7, 7);
            send_vv(rvv_lite_pkg::FUNCT6_VADD, 8, 8, 8);
        end
        send_vv(rvv_lite_pkg::FUNCT6_VSADD, 9, 7, 7);
        send_vv(rvv_lite_pkg::FUNCT6_VSADD, 10, 8, 8);
        send_vv(rvv_lite_pkg::FUNCT6_VSADD, 11, 7, 8);
        for (int n = 0; n < 3; n++) begin
            send_vv(rvv_lite_pkg::FUNCT6_VSADD, 12 + n, 1 + 2 * n, 2 + 2 * n);
        end
        end_test("saturate");

        for (int b = 0; b < 4; b++) begin
            burst_len = 1 + pick(8);
            for (int n = 0; n < burst_len; n++) begin
                send_vv(rvv_lite_pkg::FUNCT6_VADD, 1 + pick(6), 1 + pick(6), 1 + pick(6));
            end
            repeat (pick(4)) @(negedge clk);
        end
        end_test("credits");

        send_vv(rvv_lite_pkg::FUNCT6_VADD, 2, 1, 3);
        send_illegal(6'b111111, 4);
        send_vv(rvv_lite_pkg::FUNCT6_VSUB, 5, 2, 1);
        send_illegal(6'b000001, 6);
        send_vv(rvv_lite_pkg::FUNCT6_VSADD, 3, 5, 2);
        send_vi(1, 3, 5'h1b);
        send_vv(rvv_lite_pkg::FUNCT6_VADD, 6, 1, 5);
        end_test("trap");

        checks++;
        assert (retired_count == legal_sent[15:0]) else begin
            errors++;
            $display("[ERROR] retired_count got %h expected %h", retired_count, legal_sent[15:0]);
        end
        $display("Test %-12s finished with %0d errors", "count", errors - test_errors);

        $display("Sent %0d words, %0d checks, %0d errors", sent, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rvv_lite.f
+incdir+include
source/rvv_lite_pkg.sv
source/rvv_lite_if.sv
source/rvv_cmd_queue.sv
source/rvv_issue_fsm.sv
source/rvv_tag_counter.sv
source/rvv_vrf.sv
source/rvv_valu.sv
source/rvv_lite_backend.sv
dv/rvv_lite_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rvv_lite_tb -f rvv_lite.f -o rvv_lite_sim

./obj_dir/rvv_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
